// ==== hdl/cpuPkg.sv ====
package cpuPkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W      = 16;
    localparam int FUNCT_W    = 6;

    ////////////////////
    // Encodings
    ////////////////////
    // Primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        opRtype = 6'h00,
        opBeq   = 6'h04,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2B
    } opcodeE;

    // R-type funct field, instr[5:0]
    typedef enum logic [FUNCT_W-1:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2A
    } functE;

    typedef enum logic [3:0] {
        aluAnd = 4'h0,
        aluOr  = 4'h1,
        aluAdd = 4'h2,
        aluSub = 4'h6,
        aluSlt = 4'h7
    } aluCtrlE;

    // Class of ALU work chosen by decode
    typedef enum logic [1:0] {
        aluOpMem    = 2'b00,
        aluOpBranch = 2'b01,
        aluOpFunct  = 2'b10,
        aluOpImm    = 2'b11
    } aluOpE;

    ////////////////////
    // Pipeline registers
    ////////////////////
    typedef struct packed {
        logic  regWrite;
        logic  memToReg;
        logic  branch;
        logic  memRead;
        logic  memWrite;
        logic  regDst;
        logic  aluSrc;
        aluOpE aluOp;
    } ctrlT;

    typedef struct packed {
        logic [DATA_W-1:0] pc4;
        logic [DATA_W-1:0] instr;
    } ifIdT;

    typedef struct packed {
        ctrlT                  ctrl;
        logic [DATA_W-1:0]     pc4;
        logic [DATA_W-1:0]     rsData;
        logic [DATA_W-1:0]     rtData;
        logic [DATA_W-1:0]     imm;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
    } idExT;

    typedef struct packed {
        logic                  regWrite;
        logic                  memToReg;
        logic                  branch;
        logic                  memRead;
        logic                  memWrite;
        logic [DATA_W-1:0]     branchTarget;
        logic                  zero;
        logic [DATA_W-1:0]     aluResult;
        logic [DATA_W-1:0]     storeData;
        logic [REG_ADDR_W-1:0] destReg;
    } exMemT;

    typedef struct packed {
        logic                  regWrite;
        logic                  memToReg;
        logic [DATA_W-1:0]     aluResult;
        logic [DATA_W-1:0]     memData;
        logic [REG_ADDR_W-1:0] destReg;
    } memWbT;

    // One register write as seen by the register file and the outside
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] regAddr;
        logic [DATA_W-1:0]     data;
    } wbTraceT;

endpackage

// ==== hdl/fetchStage.sv ====
`timescale 1ns/100ps

module fetchStage #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          i_clk,
    input  logic                          i_rstN,
    input  logic                          i_run,
    input  logic                          i_wbCyc,
    input  logic                          i_wbStb,
    input  logic                          i_wbWe,
    input  logic [$clog2(IMEM_DEPTH)-1:0] i_wbAdr,
    input  logic [cpuPkg::DATA_W-1:0]     i_wbDatW,
    input  logic                          i_branchTaken,
    input  logic [cpuPkg::DATA_W-1:0]     i_branchTarget,
    output logic                          o_wbAck,
    output logic [cpuPkg::DATA_W-1:0]     o_wbDatR,
    output cpuPkg::ifIdT                  o_ifId
);

    localparam int IMEM_AW = $clog2(IMEM_DEPTH);

    logic [cpuPkg::DATA_W-1:0] imem [IMEM_DEPTH];
    logic [cpuPkg::DATA_W-1:0] pc;
    logic [cpuPkg::DATA_W-1:0] pc4;
    logic [cpuPkg::DATA_W-1:0] instr;
    logic                      wbReq;

    ////////////////////
    // Wishbone loader
    ////////////////////
    // A request is accepted only while no ack is out
    assign wbReq = i_wbCyc && i_wbStb && !o_wbAck;

    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            o_wbAck <= 1'b0;
        end else begin
            o_wbAck <= wbReq;
        end
    end

    always_ff @(posedge i_clk) begin
        if (wbReq && i_wbWe) begin
            imem[i_wbAdr] <= i_wbDatW;
        end
        if (wbReq && !i_wbWe) begin
            o_wbDatR <= imem[i_wbAdr];
        end
    end

    ////////////////////
    // PC and IF/ID
    ////////////////////
    assign pc4   = pc + cpuPkg::DATA_W'(4);
    assign instr = imem[pc[IMEM_AW+1:2]];

    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            pc     <= '0;
            o_ifId <= '0;
        end else if (!i_run) begin
            // Core parked at address 0, bubbles into decode
            pc     <= '0;
            o_ifId <= '0;
        end else begin
            pc           <= i_branchTaken ? i_branchTarget : pc4;
            o_ifId.pc4   <= pc4;
            o_ifId.instr <= instr;
        end
    end

    ackPulse: assert property (@(posedge i_clk) disable iff (!i_rstN)
        o_wbAck |=> !o_wbAck);

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/100ps

module regFile (
    input  logic                          i_clk,
    input  logic                          i_rstN,
    input  logic [cpuPkg::REG_ADDR_W-1:0] i_rsAddr,
    input  logic [cpuPkg::REG_ADDR_W-1:0] i_rtAddr,
    input  cpuPkg::wbTraceT               i_wb,
    output logic [cpuPkg::DATA_W-1:0]     o_rsData,
    output logic [cpuPkg::DATA_W-1:0]     o_rtData
);

    logic [cpuPkg::DATA_W-1:0] regs [32];

    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.valid && (i_wb.regAddr != '0)) begin
            regs[i_wb.regAddr] <= i_wb.data;
        end
    end

    // Same-cycle write shows through, r0 is hardwired
    function automatic logic [cpuPkg::DATA_W-1:0] readPort(
        input logic [cpuPkg::REG_ADDR_W-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end
        if (i_wb.valid && (i_wb.regAddr == addr)) begin
            return i_wb.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        o_rsData = readPort(i_rsAddr);
        o_rtData = readPort(i_rtAddr);
    end

endmodule

// ==== hdl/decodeStage.sv ====
`timescale 1ns/100ps

module decodeStage (
    input  logic            i_clk,
    input  logic            i_rstN,
    input  cpuPkg::ifIdT    i_ifId,
    input  cpuPkg::wbTraceT i_wb,
    output cpuPkg::idExT    o_idEx
);

    cpuPkg::opcodeE                  opcode;
    logic [cpuPkg::REG_ADDR_W-1:0]   rs;
    logic [cpuPkg::REG_ADDR_W-1:0]   rt;
    logic [cpuPkg::REG_ADDR_W-1:0]   rd;
    logic [cpuPkg::IMM_W-1:0]        imm16;
    logic [cpuPkg::FUNCT_W-1:0]      funct;
    logic                            functOk;
    logic [cpuPkg::DATA_W-1:0]       rsData;
    logic [cpuPkg::DATA_W-1:0]       rtData;
    cpuPkg::ctrlT                    ctrl;
    cpuPkg::idExT                    idExNext;

    ////////////////////
    // Field split
    ////////////////////
    assign opcode = cpuPkg::opcodeE'(i_ifId.instr[31:26]);
    assign rs     = i_ifId.instr[25:21];
    assign rt     = i_ifId.instr[20:16];
    assign rd     = i_ifId.instr[15:11];
    assign imm16  = i_ifId.instr[cpuPkg::IMM_W-1:0];
    assign funct  = i_ifId.instr[cpuPkg::FUNCT_W-1:0];

    // Unsupported R-type functs (incl. the all-zero nop) become bubbles
    assign functOk = funct inside {cpuPkg::fnAdd, cpuPkg::fnSub, cpuPkg::fnAnd,
                                   cpuPkg::fnOr, cpuPkg::fnSlt};

    ////////////////////
    // Control unit
    ////////////////////
    always_comb begin
        ctrl = '0;
        case (opcode)
            cpuPkg::opRtype: begin
                if (functOk) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.regDst   = 1'b1;
                    ctrl.aluOp    = cpuPkg::aluOpFunct;
                end
            end
            cpuPkg::opAddi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = cpuPkg::aluOpImm;
            end
            cpuPkg::opLw: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = cpuPkg::aluOpMem;
            end
            cpuPkg::opSw: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = cpuPkg::aluOpMem;
            end
            cpuPkg::opBeq: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = cpuPkg::aluOpBranch;
            end
            default: ctrl = '0;
        endcase
    end

    regFile uRegFile (
        .i_clk    (i_clk),
        .i_rstN   (i_rstN),
        .i_rsAddr (rs),
        .i_rtAddr (rt),
        .i_wb     (i_wb),
        .o_rsData (rsData),
        .o_rtData (rtData)
    );

    ////////////////////
    // ID/EX
    ////////////////////
    always_comb begin
        idExNext.ctrl   = ctrl;
        idExNext.pc4    = i_ifId.pc4;
        idExNext.rsData = rsData;
        idExNext.rtData = rtData;
        idExNext.imm    = {{(cpuPkg::DATA_W - cpuPkg::IMM_W){imm16[cpuPkg::IMM_W-1]}}, imm16};
        idExNext.rt     = rt;
        idExNext.rd     = rd;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            o_idEx.ctrl <= '0;
        end else begin
            o_idEx <= idExNext;
        end
    end

    memExclusive: assert property (@(posedge i_clk) disable iff (!i_rstN)
        !(o_idEx.ctrl.memRead && o_idEx.ctrl.memWrite));

endmodule

// ==== hdl/executeStage.sv ====
`timescale 1ns/100ps

module executeStage (
    input  logic          i_clk,
    input  logic          i_rstN,
    input  cpuPkg::idExT  i_idEx,
    output cpuPkg::exMemT o_exMem
);

    cpuPkg::aluCtrlE                 aluCtrl;
    logic [cpuPkg::DATA_W-1:0]       opA;
    logic [cpuPkg::DATA_W-1:0]       opB;
    logic [cpuPkg::DATA_W-1:0]       aluResult;
    logic [cpuPkg::DATA_W-1:0]       branchTarget;
    logic [cpuPkg::REG_ADDR_W-1:0]   destReg;
    logic                            zero;

    ////////////////////
    // ALU control
    ////////////////////
    always_comb begin
        aluCtrl = cpuPkg::aluAdd;
        case (i_idEx.ctrl.aluOp)
            cpuPkg::aluOpMem:    aluCtrl = cpuPkg::aluAdd;
            cpuPkg::aluOpImm:    aluCtrl = cpuPkg::aluAdd;
            cpuPkg::aluOpBranch: aluCtrl = cpuPkg::aluSub;
            cpuPkg::aluOpFunct: begin
                // funct sits in the low bits of the extended immediate
                case (cpuPkg::functE'(i_idEx.imm[cpuPkg::FUNCT_W-1:0]))
                    cpuPkg::fnAdd: aluCtrl = cpuPkg::aluAdd;
                    cpuPkg::fnSub: aluCtrl = cpuPkg::aluSub;
                    cpuPkg::fnAnd: aluCtrl = cpuPkg::aluAnd;
                    cpuPkg::fnOr:  aluCtrl = cpuPkg::aluOr;
                    cpuPkg::fnSlt: aluCtrl = cpuPkg::aluSlt;
                    default:       aluCtrl = cpuPkg::aluCtrlE'(4'hF);
                endcase
            end
            default: aluCtrl = cpuPkg::aluAdd;
        endcase
    end

    ////////////////////
    // ALU
    ////////////////////
    assign opA = i_idEx.rsData;
    assign opB = i_idEx.ctrl.aluSrc ? i_idEx.imm : i_idEx.rtData;

    always_comb begin
        case (aluCtrl)
            cpuPkg::aluAdd: aluResult = opA + opB;
            cpuPkg::aluSub: aluResult = opA - opB;
            cpuPkg::aluAnd: aluResult = opA & opB;
            cpuPkg::aluOr:  aluResult = opA | opB;
            // Signed compare
            cpuPkg::aluSlt: aluResult = cpuPkg::DATA_W'($signed(opA) < $signed(opB));
            default:        aluResult = '0;
        endcase
    end

    assign zero         = (aluResult == '0);
    assign branchTarget = i_idEx.pc4 + {i_idEx.imm[cpuPkg::DATA_W-3:0], 2'b00};
    assign destReg      = i_idEx.ctrl.regDst ? i_idEx.rd : i_idEx.rt;

    ////////////////////
    // EX/MEM
    ////////////////////
    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            o_exMem.regWrite <= 1'b0;
            o_exMem.memToReg <= 1'b0;
            o_exMem.branch   <= 1'b0;
            o_exMem.memRead  <= 1'b0;
            o_exMem.memWrite <= 1'b0;
        end else begin
            o_exMem.regWrite     <= i_idEx.ctrl.regWrite;
            o_exMem.memToReg     <= i_idEx.ctrl.memToReg;
            o_exMem.branch       <= i_idEx.ctrl.branch;
            o_exMem.memRead      <= i_idEx.ctrl.memRead;
            o_exMem.memWrite     <= i_idEx.ctrl.memWrite;
            o_exMem.branchTarget <= branchTarget;
            o_exMem.zero         <= zero;
            o_exMem.aluResult    <= aluResult;
            o_exMem.storeData    <= i_idEx.rtData;
            o_exMem.destReg      <= destReg;
        end
    end

    // Decode only lets supported functs carry control bits
    aluCtrlKnown: assert property (@(posedge i_clk) disable iff (!i_rstN)
        (i_idEx.ctrl.regWrite || i_idEx.ctrl.branch) |->
            (aluCtrl inside {cpuPkg::aluAdd, cpuPkg::aluSub, cpuPkg::aluAnd,
                             cpuPkg::aluOr, cpuPkg::aluSlt}));

endmodule

// ==== hdl/memWritebackStage.sv ====
`timescale 1ns/100ps

module memWritebackStage #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic                      i_clk,
    input  logic                      i_rstN,
    input  cpuPkg::exMemT             i_exMem,
    output logic                      o_branchTaken,
    output logic [cpuPkg::DATA_W-1:0] o_branchTarget,
    output cpuPkg::wbTraceT           o_wb
);

    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    logic [cpuPkg::DATA_W-1:0] dmem [DMEM_DEPTH];
    logic [DMEM_AW-1:0]        dmemIdx;
    logic [cpuPkg::DATA_W-1:0] memData;
    cpuPkg::memWbT             memWb;

    ////////////////////
    // Data memory
    ////////////////////
    // Byte address from the ALU, low two bits dropped
    assign dmemIdx = i_exMem.aluResult[DMEM_AW+1:2];
    assign memData = i_exMem.memRead ? dmem[dmemIdx] : '0;

    always_ff @(posedge i_clk) begin
        if (i_exMem.memWrite) begin
            dmem[dmemIdx] <= i_exMem.storeData;
        end
    end

    // Redirect to fetch
    assign o_branchTaken  = i_exMem.branch && i_exMem.zero;
    assign o_branchTarget = i_exMem.branchTarget;

    ////////////////////
    // MEM/WB and writeback
    ////////////////////
    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            memWb.regWrite <= 1'b0;
            memWb.memToReg <= 1'b0;
        end else begin
            memWb.regWrite  <= i_exMem.regWrite;
            memWb.memToReg  <= i_exMem.memToReg;
            memWb.aluResult <= i_exMem.aluResult;
            memWb.memData   <= memData;
            memWb.destReg   <= i_exMem.destReg;
        end
    end

    always_comb begin
        o_wb.valid   = memWb.regWrite && (memWb.destReg != '0);
        o_wb.regAddr = memWb.destReg;
        o_wb.data    = memWb.memToReg ? memWb.memData : memWb.aluResult;
    end

endmodule

// ==== hdl/pipelineCpu.sv ====
`timescale 1ns/100ps

module pipelineCpu #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  logic                          i_clk,
    input  logic                          i_rstN,
    input  logic                          i_run,
    input  logic                          i_wbCyc,
    input  logic                          i_wbStb,
    input  logic                          i_wbWe,
    input  logic [$clog2(IMEM_DEPTH)-1:0] i_wbAdr,
    input  logic [cpuPkg::DATA_W-1:0]     i_wbDatW,
    output logic                          o_wbAck,
    output logic [cpuPkg::DATA_W-1:0]     o_wbDatR,
    output cpuPkg::wbTraceT               o_trace
);

    cpuPkg::ifIdT              ifId;
    cpuPkg::idExT              idEx;
    cpuPkg::exMemT             exMem;
    cpuPkg::wbTraceT           wbBus;
    logic                      branchTaken;
    logic [cpuPkg::DATA_W-1:0] branchTarget;

    ////////////////////
    // Input side
    ////////////////////
    fetchStage #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) uFetch (
        .i_clk          (i_clk),
        .i_rstN         (i_rstN),
        .i_run          (i_run),
        .i_wbCyc        (i_wbCyc),
        .i_wbStb        (i_wbStb),
        .i_wbWe         (i_wbWe),
        .i_wbAdr        (i_wbAdr),
        .i_wbDatW       (i_wbDatW),
        .i_branchTaken  (branchTaken),
        .i_branchTarget (branchTarget),
        .o_wbAck        (o_wbAck),
        .o_wbDatR       (o_wbDatR),
        .o_ifId         (ifId)
    );

    ////////////////////
    // Processing
    ////////////////////
    decodeStage uDecode (
        .i_clk  (i_clk),
        .i_rstN (i_rstN),
        .i_ifId (ifId),
        .i_wb   (wbBus),
        .o_idEx (idEx)
    );

    executeStage uExecute (
        .i_clk   (i_clk),
        .i_rstN  (i_rstN),
        .i_idEx  (idEx),
        .o_exMem (exMem)
    );

    ////////////////////
    // Output side
    ////////////////////
    memWritebackStage #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) uMemWb (
        .i_clk          (i_clk),
        .i_rstN         (i_rstN),
        .i_exMem        (exMem),
        .o_branchTaken  (branchTaken),
        .o_branchTarget (branchTarget),
        .o_wb           (wbBus)
    );

    // Trace is the register file write port
    assign o_trace = wbBus;

endmodule

// ==== testbench/tbProgram.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// ISA encodings
localparam logic [5:0] OP_RTYPE = 6'h00;
localparam logic [5:0] OP_BEQ   = 6'h04;
localparam logic [5:0] OP_ADDI  = 6'h08;
localparam logic [5:0] OP_LW    = 6'h23;
localparam logic [5:0] OP_SW    = 6'h2B;
localparam logic [5:0] OP_UNDEF = 6'h3F;
localparam logic [5:0] FN_ADD   = 6'h20;
localparam logic [5:0] FN_SUB   = 6'h22;
localparam logic [5:0] FN_AND   = 6'h24;
localparam logic [5:0] FN_OR    = 6'h25;
localparam logic [5:0] FN_SLT   = 6'h2A;

function automatic logic [31:0] signExtend(input logic [15:0] v);
    return {{16{v[15]}}, v};
endfunction

function automatic logic [31:0] encodeI(input logic [5:0] op, input int rt, input int rs,
                                        input logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
endfunction

function automatic logic [31:0] encodeR(input logic [5:0] fn, input int rd, input int rs,
                                        input int rt);
    return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
endfunction

task automatic appendWord(input logic [31:0] word);
    progMem[progLen] = word;
    progLen++;
endtask

task automatic insertNop();
    appendWord(32'h0000_0000);
endtask

// Writes to r0 leave no trace entry
task automatic expectWrite(input int testId, input int rd, input logic [31:0] value);
    if (rd != 0) begin
        expReg[expCount]  = 5'(rd);
        expData[expCount] = value;
        expTest[expCount] = testId;
        expCount++;
        model[rd] = value;
    end
endtask

task automatic addImmediate(input int testId, input int rt, input int rs,
                            input logic [15:0] imm, input bit executes);
    appendWord(encodeI(OP_ADDI, rt, rs, imm));
    if (executes) begin
        expectWrite(testId, rt, model[rs] + signExtend(imm));
    end
endtask

task automatic aluRegister(input int testId, input logic [5:0] fn, input int rd,
                           input int rs, input int rt);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] value;
    a = model[rs];
    b = model[rt];
    case (fn)
        FN_ADD:  value = a + b;
        FN_SUB:  value = a - b;
        FN_AND:  value = a & b;
        FN_OR:   value = a | b;
        FN_SLT:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        default: value = 32'd0;
    endcase
    appendWord(encodeR(fn, rd, rs, rt));
    expectWrite(testId, rd, value);
endtask

task automatic storeWord(input int rt, input int rs, input logic [15:0] imm);
    dataModel[int'(model[rs] + signExtend(imm))] = model[rt];
    appendWord(encodeI(OP_SW, rt, rs, imm));
endtask

task automatic loadWord(input int testId, input int rt, input int rs, input logic [15:0] imm);
    appendWord(encodeI(OP_LW, rt, rs, imm));
    expectWrite(testId, rt, dataModel[int'(model[rs] + signExtend(imm))]);
endtask

task automatic branchEqual(input int rs, input int rt, input logic [15:0] offset);
    appendWord(encodeI(OP_BEQ, rt, rs, offset));
endtask

////////////////////
// Test program
////////////////////
// Consumers sit three or more words after their producers
task automatic buildProgram();
    logic [15:0] immA;
    logic [15:0] immB;
    logic [15:0] immC;
    logic [15:0] immD;
    // r1 negative and r2 positive so slt tells signed from unsigned
    immA = 16'($urandom) | 16'h8000;
    immB = 16'($urandom % 32'd32767) + 16'd1;
    immD = 16'($urandom);
    // ALU ops in words 0 to 9
    addImmediate(3, 1, 0, immA, 1'b1);
    addImmediate(3, 2, 0, immB, 1'b1);
    insertNop();
    insertNop();
    aluRegister(3, FN_ADD, 3, 1, 2);
    aluRegister(3, FN_SUB, 4, 1, 2);
    aluRegister(3, FN_AND, 5, 1, 2);
    aluRegister(3, FN_OR, 6, 1, 2);
    aluRegister(3, FN_SLT, 7, 1, 2);
    aluRegister(3, FN_SLT, 8, 2, 1);
    // Store and load in words 10 to 16
    addImmediate(4, 9, 0, 16'd8, 1'b1);
    insertNop();
    insertNop();
    storeWord(3, 9, 16'd0);
    storeWord(4, 9, 16'd4);
    loadWord(4, 10, 9, 16'd0);
    loadWord(4, 11, 9, 16'd4);
    // Branches in words 17 to 33
    // r12 differs from r3 so the second beq falls through
    do begin
        immC = 16'($urandom);
    end while (signExtend(immC) == model[3]);
    addImmediate(5, 12, 0, immC, 1'b1);
    addImmediate(5, 13, 0, immC, 1'b1);
    insertNop();
    insertNop();
    // Taken beq at word 21 jumps to word 27
    branchEqual(12, 13, 16'd5);
    insertNop();
    insertNop();
    insertNop();
    addImmediate(5, 14, 0, 16'($urandom), 1'b0);
    addImmediate(5, 15, 0, 16'($urandom), 1'b0);
    addImmediate(5, 16, 0, immD, 1'b1);
    // Not-taken beq at word 28 would jump to word 33
    branchEqual(12, 3, 16'd4);
    insertNop();
    insertNop();
    insertNop();
    addImmediate(5, 17, 0, 16'($urandom), 1'b1);
    addImmediate(5, 18, 0, 16'($urandom), 1'b1);
    // Writes to r0 and an undefined opcode in words 34 to 39
    addImmediate(6, 0, 0, 16'($urandom), 1'b1);
    appendWord(encodeI(OP_UNDEF, 19, 1, 16'($urandom)));
    insertNop();
    insertNop();
    aluRegister(6, FN_ADD, 20, 0, 0);
    aluRegister(6, FN_OR, 21, 0, 1);
endtask

`endif

// ==== testbench/tbPipelineCpu.sv ====
`timescale 1ns/100ps

module tbPipelineCpu;

    localparam int IMEM_DEPTH   = 64;
    localparam int DMEM_DEPTH   = 64;
    localparam int IMEM_AW      = $clog2(IMEM_DEPTH);
    localparam int NUM_TESTS    = 6;
    localparam int DRAIN_CYCLES = 8;
    // Reset, idle check, then a write and a read of two clocks per word
    localparam int LOAD_CYCLES  = 2 + 4 + 2 * IMEM_DEPTH * 2;

    logic                 clk = 1'b0;
    logic                 rstN;
    logic                 run;
    logic                 wbCyc;
    logic                 wbStb;
    logic                 wbWe;
    logic [IMEM_AW-1:0]   wbAdr;
    logic [31:0]          wbDatW;
    logic                 wbAck;
    logic [31:0]          wbDatR;
    cpuPkg::wbTraceT      trace;

    logic [31:0] progMem [IMEM_DEPTH];
    int          progLen;
    logic [4:0]  expReg [IMEM_DEPTH];
    logic [31:0] expData [IMEM_DEPTH];
    int          expTest [IMEM_DEPTH];
    int          expCount;
    int          expIdx;
    logic [31:0] model [32];
    logic [31:0] dataModel [int];
    int          testErrors [1:NUM_TESTS];
    string       testNames [1:NUM_TESTS];
    int          cycleCount = 0;
    int          timeoutLimit = 100000;
    int          seedValue;
    int          passCount;
    int          totalErrors;
    logic [31:0] readWord;

`include "tbProgram.svh"

    pipelineCpu #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_dut (
        .i_clk    (clk),
        .i_rstN   (rstN),
        .i_run    (run),
        .i_wbCyc  (wbCyc),
        .i_wbStb  (wbStb),
        .i_wbWe   (wbWe),
        .i_wbAdr  (wbAdr),
        .i_wbDatW (wbDatW),
        .o_wbAck  (wbAck),
        .o_wbDatR (wbDatR),
        .o_trace  (trace)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutLimit) begin
            $display("Timeout: the trace never completed within %0d cycles", timeoutLimit);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic countError(input int testId);
        testErrors[testId]++;
    endtask

    task automatic reportTest(input int testId);
        if (testErrors[testId] == 0) begin
            $display("test %0d %s: ok", testId, testNames[testId]);
        end else begin
            $display("test %0d %s: %0d errors", testId, testNames[testId], testErrors[testId]);
        end
    endtask

    ////////////////////
    // Wishbone master
    ////////////////////
    // Called on a falling edge, returns on a falling edge
    task automatic wbAccess(input logic we, input int adr, input logic [31:0] datW,
                            output logic [31:0] datR);
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = we;
        wbAdr  = IMEM_AW'(adr);
        wbDatW = datW;
        @(negedge clk);
        while (!wbAck) begin
            @(negedge clk);
        end
        datR  = wbDatR;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
        @(negedge clk);
        assert (!wbAck) else begin
            $display("Wishbone ack stayed high for more than one cycle at word %0d", adr);
            countError(2);
        end
    endtask

    ////////////////////
    // Trace checker
    ////////////////////
    task automatic checkTrace();
        int testId;
        assert (expIdx < expCount) else begin
            $display("Unexpected trace entry for register %0d after the program ended",
                     trace.regAddr);
            countError(expTest[expCount-1]);
        end
        if (expIdx < expCount) begin
            testId = expTest[expIdx];
            assert (trace.regAddr == expReg[expIdx]) else begin
                $display("FAIL o_trace.regAddr: got %h expected %h",
                         trace.regAddr, expReg[expIdx]);
                countError(testId);
            end
            assert (trace.data == expData[expIdx]) else begin
                $display("FAIL o_trace.data (r%0d): got %h expected %h",
                         expReg[expIdx], trace.data, expData[expIdx]);
                countError(testId);
            end
            expIdx++;
            if ((expIdx < expCount) && (expTest[expIdx] != testId)) begin
                reportTest(testId);
            end
        end
    endtask

    initial begin
        seedValue = $urandom(65363);
        rstN   = 1'b0;
        run    = 1'b0;
        wbCyc  = 1'b0;
        wbStb  = 1'b0;
        wbWe   = 1'b0;
        wbAdr  = '0;
        wbDatW = '0;
        testNames[1] = "reset";
        testNames[2] = "wishbone load";
        testNames[3] = "addi and R-type";
        testNames[4] = "sw and lw";
        testNames[5] = "beq";
        testNames[6] = "r0 and undefined opcode";
        for (int i = 1; i <= NUM_TESTS; i++) begin
            testErrors[i] = 0;
        end
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            progMem[i] = '0;
        end
        progLen  = 0;
        expCount = 0;
        expIdx   = 0;
        buildProgram();
        timeoutLimit = LOAD_CYCLES + progLen + 4 + 20;

        repeat (2) @(negedge clk);
        rstN = 1'b1;

        // Nothing may move without a request
        repeat (4) begin
            @(negedge clk);
            assert (!trace.valid && !wbAck) else begin
                $display("Trace valid or Wishbone ack active after reset with no request");
                countError(1);
            end
        end
        reportTest(1);

        // Whole memory is loaded, unused words stay nops
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            wbAccess(1'b1, i, progMem[i], readWord);
        end
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            wbAccess(1'b0, i, '0, readWord);
            assert (readWord == progMem[i]) else begin
                $display("FAIL o_wbDatR word %0d: got %h expected %h", i, readWord, progMem[i]);
                countError(2);
            end
        end
        reportTest(2);

        run = 1'b1;
        while (expIdx < expCount) begin
            @(negedge clk);
            if (trace.valid) begin
                checkTrace();
            end
        end
        // Skipped or extra writes would show up here
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            if (trace.valid) begin
                checkTrace();
            end
        end
        reportTest(expTest[expCount-1]);

        passCount   = 0;
        totalErrors = 0;
        for (int i = 1; i <= NUM_TESTS; i++) begin
            totalErrors += testErrors[i];
            if (testErrors[i] == 0) begin
                passCount++;
            end
        end
        $display("Tests: %0d passed, %0d failed, %0d errors",
                 passCount, NUM_TESTS - passCount, totalErrors);
        if (totalErrors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+testbench
hdl/cpuPkg.sv
hdl/fetchStage.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memWritebackStage.sv
hdl/pipelineCpu.sv
testbench/tbPipelineCpu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tbPipelineCpu \
    -f filelist.f -o simPipelineCpu
./obj_dir/simPipelineCpu | tee sim.log

if grep -q "^Done: no errors$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
